// ==== include/mips_cfg.svh ====
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

`define RESET_PC    32'h0000_3000   // first fetch address
`define DMEM_WORDS  1024            // data memory depth, word indexed from addr[11:2]

// primary opcodes
`define OP_RTYPE    6'h00
`define OP_ORI      6'h0d
`define OP_LUI      6'h0f
`define OP_LW       6'h23
`define OP_SW       6'h2b
`define OP_BEQ      6'h04

// funct field of R-type
`define FN_ADDU     6'h21
`define FN_SUBU     6'h23

// need times, cycles after decode until the operand is consumed
`define TUSE_BRANCH 2'd0            // compare sits in decode
`define TUSE_ALU    2'd1
`define TUSE_STORE  2'd2            // store data only needed in memory
`define TUSE_NONE   2'd3            // operand not read, never stalls

// ready times, cycles until the result can be forwarded
`define TNEW_ALU_E  2'd1
`define TNEW_LOAD_E 2'd2
`define TNEW_LOAD_M 2'd1

`endif

// ==== hdl/mipsPkg.sv ====
package mipsPkg;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFields_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } iFields_t;

    // same 32-bit word, seen as R-type or I-type
    typedef union packed {
        rFields_t r;
        iFields_t i;
    } instrWord_t;

    typedef enum logic [1:0] {aluAdd, aluSub, aluOr, aluLui} aluOp_t;

    typedef struct packed {
        aluOp_t     aluOp;
        logic       aluSrcImm;      // immediate as second operand
        logic       zeroExt;        // ori zero-extends
        logic       memWrite;
        logic       memToReg;       // load result goes back
        logic       regWrite;
        logic [1:0] tNew;           // ready time seen from execute
    } ctrl_t;

    typedef struct packed {
        logic [31:0] pc;
        instrWord_t  instr;
        ctrl_t       ctrl;
        logic [31:0] rsData;
        logic [31:0] rtData;
        logic [31:0] imm;           // already extended
        logic [4:0]  dst;
    } deStage_t;

    typedef struct packed {
        logic [31:0] pc;
        ctrl_t       ctrl;
        logic [4:0]  rtNum;         // for store data forwarding
        logic [4:0]  dst;
        logic [31:0] aluResult;
        logic [31:0] storeData;
    } emStage_t;

    typedef struct packed {
        logic [31:0] pc;
        ctrl_t       ctrl;
        logic [4:0]  dst;
        logic [31:0] aluResult;
        logic [31:0] loadData;
    } mwStage_t;

    typedef enum logic [1:0] {fwdNone, fwdFromMem, fwdFromWb} fwdSel_t;

    typedef struct packed {
        fwdSel_t dRs;
        fwdSel_t dRt;
        fwdSel_t eRs;
        fwdSel_t eRt;
        fwdSel_t mRt;               // store data in memory stage
    } hazardFwd_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  regNum;
        logic [31:0] data;
    } regCommit_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] addr;          // byte address, word aligned
        logic [31:0] data;
    } memCommit_t;

endpackage

// ==== hdl/fetchUnit.sv ====
`timescale 1ns/1ns
`include "mips_cfg.svh"

module fetchUnit import mipsPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic        stall,
    input  logic        branchTaken,
    input  logic [31:0] branchTarget,
    output logic [31:0] instrAddr,
    input  logic [31:0] instr,
    output instrWord_t  dInstr,
    output logic [31:0] dPc
);

    logic [31:0] pc;
    logic [31:0] pcNext;

    assign instrAddr = pc;                                  // ROM answers in the same cycle

    // the slot after a beq is already being fetched when beq resolves
    assign pcNext = branchTaken ? branchTarget : pc + 32'd4;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc     <= `RESET_PC;
            dInstr <= '0;                                   // nop in decode
            dPc    <= '0;
        end else if (!stall) begin                          // hold pc and decode reg on stall
            pc     <= pcNext;
            dInstr <= instr;
            dPc    <= pc;
        end
    end

    // branch targets are offset << 2, so alignment holds through every redirect
    assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
        else $error("fetch pc 0x%08h not word aligned", pc);

endmodule

// ==== hdl/regFile.sv ====
`timescale 1ns/1ns

module regFile (
    input  logic        clk,
    input  logic        rstN,
    input  logic [4:0]  rsNum,
    input  logic [4:0]  rtNum,
    input  logic        wrEn,
    input  logic [4:0]  wrNum,
    input  logic [31:0] wrData,
    output logic [31:0] rsData,
    output logic [31:0] rtData
);

    logic [31:0] regs [1:31];                               // $0 has no storage

    function automatic logic [31:0] readReg(input logic [4:0] num);
        if (num == 5'd0) begin
            return '0;
        end
        if (wrEn && wrNum == num) begin                     // writeback in this cycle wins
            return wrData;
        end
        return regs[num];
    endfunction

    always_comb begin
        rsData = readReg(rsNum);
        rtData = readReg(rtNum);
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrNum != 5'd0) begin
            regs[wrNum] <= wrData;                          // end of writeback
        end
    end

endmodule

// ==== hdl/decodeStage.sv ====
`timescale 1ns/1ns
`include "mips_cfg.svh"

module decodeStage import mipsPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  instrWord_t  dInstr,
    input  logic [31:0] dPc,
    input  logic        stall,
    input  hazardFwd_t  hazardFwd,
    input  logic [31:0] memFwdData,
    input  logic [31:0] rsData,
    input  logic [31:0] rtData,
    output ctrl_t       dCtrl,
    output logic        branchTaken,
    output logic [31:0] branchTarget,
    output deStage_t    deStage
);

    logic [31:0] rsVal;
    logic [31:0] rtVal;
    logic [31:0] immExt;
    logic [4:0]  dst;
    logic        isBeq;

    always_comb begin
        dCtrl = '0;                                         // anything unlisted runs as nop
        case (dInstr.i.op)
            `OP_RTYPE: begin
                if (dInstr.r.funct == `FN_ADDU || dInstr.r.funct == `FN_SUBU) begin
                    dCtrl.aluOp    = (dInstr.r.funct == `FN_SUBU) ? aluSub : aluAdd;
                    dCtrl.regWrite = 1'b1;
                    dCtrl.tNew     = `TNEW_ALU_E;
                end
            end
            `OP_ORI: begin
                dCtrl.aluOp     = aluOr;
                dCtrl.aluSrcImm = 1'b1;
                dCtrl.zeroExt   = 1'b1;
                dCtrl.regWrite  = 1'b1;
                dCtrl.tNew      = `TNEW_ALU_E;
            end
            `OP_LUI: begin
                dCtrl.aluOp     = aluLui;                   // low half of imm shifted up
                dCtrl.aluSrcImm = 1'b1;
                dCtrl.regWrite  = 1'b1;
                dCtrl.tNew      = `TNEW_ALU_E;
            end
            `OP_LW: begin
                dCtrl.aluSrcImm = 1'b1;                     // base + offset
                dCtrl.memToReg  = 1'b1;
                dCtrl.regWrite  = 1'b1;
                dCtrl.tNew      = `TNEW_LOAD_E;
            end
            `OP_SW: begin
                dCtrl.aluSrcImm = 1'b1;
                dCtrl.memWrite  = 1'b1;
            end
            default: ;                                      // beq needs no control bits
        endcase
    end

    assign isBeq  = dInstr.i.op == `OP_BEQ;
    assign dst    = (dInstr.i.op == `OP_RTYPE) ? dInstr.r.rd : dInstr.i.rt;
    assign immExt = dCtrl.zeroExt ? {16'h0, dInstr.i.imm16}
                                  : {{16{dInstr.i.imm16[15]}}, dInstr.i.imm16};

    // only the memory stage feeds decode, writeback goes through the regfile bypass
    assign rsVal = (hazardFwd.dRs == fwdFromMem) ? memFwdData : rsData;
    assign rtVal = (hazardFwd.dRt == fwdFromMem) ? memFwdData : rtData;

    assign branchTaken  = isBeq && (rsVal == rtVal);
    assign branchTarget = dPc + 32'd4 + {immExt[29:0], 2'b00};  // relative to the slot

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            deStage <= '0;
        end else if (stall) begin
            deStage <= '0;                                  // bubble into execute
        end else begin
            deStage <= '{pc: dPc, instr: dInstr, ctrl: dCtrl, rsData: rsVal,
                         rtData: rtVal, imm: immExt, dst: dst};
        end
    end

    // undefined words must neither write state nor redirect fetch
    assert property (@(posedge clk) disable iff (!rstN)
        !(dInstr.i.op inside {`OP_RTYPE, `OP_ORI, `OP_LUI, `OP_LW, `OP_SW, `OP_BEQ})
        |-> (dCtrl == '0) && !branchTaken)
        else $error("unknown opcode 0x%02h not decoded as nop", dInstr.i.op);

endmodule

// ==== hdl/hazardUnit.sv ====
`timescale 1ns/1ns
`include "mips_cfg.svh"

module hazardUnit import mipsPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  instrWord_t dInstr,
    input  ctrl_t      dCtrl,
    input  deStage_t   deStage,
    input  emStage_t   emStage,
    input  mwStage_t   mwStage,
    output logic       stall,
    output hazardFwd_t hazardFwd
);

    logic [1:0] tUseRs;
    logic [1:0] tUseRt;
    logic [1:0] eRemain;
    logic [1:0] mRemain;
    logic       isBeq;

    function automatic logic writes(ctrl_t ctrl, logic [4:0] dst, logic [4:0] src);
        return ctrl.regWrite && dst == src && src != 5'd0;  // $0 never depends
    endfunction

    // result still too far away for the stage that needs it
    function automatic logic late(logic [4:0] src, logic [1:0] tUse);
        return (writes(deStage.ctrl, deStage.dst, src) && eRemain > tUse)
            || (writes(emStage.ctrl, emStage.dst, src) && mRemain > tUse);
    endfunction

    // nearest writer first, a load in memory has no value yet
    function automatic fwdSel_t pickFwd(logic [4:0] src, logic wbAllowed);
        if (writes(emStage.ctrl, emStage.dst, src) && !emStage.ctrl.memToReg) begin
            return fwdFromMem;
        end
        if (wbAllowed && writes(mwStage.ctrl, mwStage.dst, src)) begin
            return fwdFromWb;
        end
        return fwdNone;
    endfunction

    always_comb begin
        isBeq   = dInstr.i.op == `OP_BEQ;
        eRemain = deStage.ctrl.tNew;
        mRemain = emStage.ctrl.memToReg ? `TNEW_LOAD_M : 2'd0;

        if (isBeq) begin
            tUseRs = `TUSE_BRANCH;
        end else if ((dCtrl.regWrite || dCtrl.memWrite) && dCtrl.aluOp != aluLui) begin
            tUseRs = `TUSE_ALU;                             // base or first source
        end else begin
            tUseRs = `TUSE_NONE;                            // lui, nop
        end

        if (isBeq) begin
            tUseRt = `TUSE_BRANCH;
        end else if (dCtrl.memWrite) begin
            tUseRt = `TUSE_STORE;
        end else if (dCtrl.regWrite && !dCtrl.aluSrcImm) begin
            tUseRt = `TUSE_ALU;                             // addu, subu
        end else begin
            tUseRt = `TUSE_NONE;
        end

        stall = late(dInstr.r.rs, tUseRs) || late(dInstr.r.rt, tUseRt);

        hazardFwd.dRs = pickFwd(dInstr.r.rs, 1'b0);         // regfile covers writeback
        hazardFwd.dRt = pickFwd(dInstr.r.rt, 1'b0);
        hazardFwd.eRs = pickFwd(deStage.instr.r.rs, 1'b1);
        hazardFwd.eRt = pickFwd(deStage.instr.r.rt, 1'b1);
        hazardFwd.mRt = writes(mwStage.ctrl, mwStage.dst, emStage.rtNum) ? fwdFromWb : fwdNone;
    end

    // worst case is lw then beq, load in execute then in memory
    assert property (@(posedge clk) disable iff (!rstN) stall ##1 stall |=> !stall)
        else $error("stall held for more than 2 cycles");

endmodule

// ==== hdl/executeStage.sv ====
`timescale 1ns/1ns

module executeStage import mipsPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  deStage_t    deStage,
    input  hazardFwd_t  hazardFwd,
    input  logic [31:0] memFwdData,
    input  logic [31:0] wbData,
    output emStage_t    emStage
);

    logic [31:0] opA;
    logic [31:0] rtFwd;
    logic [31:0] opB;
    logic [31:0] aluResult;

    function automatic logic [31:0] fwdMux(fwdSel_t sel, logic [31:0] regVal);
        case (sel)
            fwdFromMem: return memFwdData;
            fwdFromWb:  return wbData;
            default:    return regVal;                      // value latched in decode
        endcase
    endfunction

    always_comb begin
        opA   = fwdMux(hazardFwd.eRs, deStage.rsData);
        rtFwd = fwdMux(hazardFwd.eRt, deStage.rtData);
        opB   = deStage.ctrl.aluSrcImm ? deStage.imm : rtFwd;
    end

    always_comb begin
        case (deStage.ctrl.aluOp)
            aluAdd:  aluResult = opA + opB;                 // also lw/sw address
            aluSub:  aluResult = opA - opB;
            aluOr:   aluResult = opA | opB;
            default: aluResult = {opB[15:0], 16'h0};        // lui
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            emStage <= '0;
        end else begin                                      // never stalls
            emStage <= '{pc: deStage.pc, ctrl: deStage.ctrl, rtNum: deStage.instr.i.rt,
                         dst: deStage.dst, aluResult: aluResult, storeData: rtFwd};
        end
    end

endmodule

// ==== hdl/memoryStage.sv ====
`timescale 1ns/1ns
`include "mips_cfg.svh"

module memoryStage import mipsPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  emStage_t    emStage,
    input  hazardFwd_t  hazardFwd,
    input  logic [31:0] wbData,
    output mwStage_t    mwStage,
    output memCommit_t  memCommit,
    output regCommit_t  regCommit
);

    localparam int addrBits = $clog2(`DMEM_WORDS);

    logic [31:0]         dmem [`DMEM_WORDS];
    logic [addrBits-1:0] wordIdx;
    logic [31:0]         storeData;

    assign wordIdx = emStage.aluResult[addrBits+1:2];

    // a load just ahead of the store may still land its data here
    assign storeData = (hazardFwd.mRt == fwdFromWb) ? wbData : emStage.storeData;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (emStage.ctrl.memWrite) begin
            dmem[wordIdx] <= storeData;                     // write at end of memory stage
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mwStage <= '0;
        end else begin
            mwStage <= '{pc: emStage.pc, ctrl: emStage.ctrl, dst: emStage.dst,
                         aluResult: emStage.aluResult, loadData: dmem[wordIdx]};
        end
    end

    // store seen in the cycle it sits in memory
    assign memCommit = '{valid: emStage.ctrl.memWrite,
                         pc:    emStage.pc,
                         addr:  emStage.aluResult,
                         data:  storeData};

    // data field doubles as the writeback value for the whole core
    assign regCommit = '{valid:  mwStage.ctrl.regWrite && mwStage.dst != 5'd0,
                         pc:     mwStage.pc,
                         regNum: mwStage.dst,
                         data:   mwStage.ctrl.memToReg ? mwStage.loadData : mwStage.aluResult};

    assert property (@(posedge clk) disable iff (!rstN)
        emStage.ctrl.memWrite |-> emStage.aluResult[1:0] == 2'b00)
        else $error("store to unaligned address 0x%08h", emStage.aluResult);

endmodule

// ==== hdl/mipsCore.sv ====
`timescale 1ns/1ns

module mipsCore import mipsPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    output logic [31:0] instrAddr,
    input  logic [31:0] instr,
    output regCommit_t  regCommit,
    output memCommit_t  memCommit
);

    instrWord_t  dInstr;
    logic [31:0] dPc;
    ctrl_t       dCtrl;
    logic [31:0] rsData;
    logic [31:0] rtData;
    logic        stall;
    logic        branchTaken;
    logic [31:0] branchTarget;
    hazardFwd_t  hazardFwd;
    deStage_t    deStage;
    emStage_t    emStage;
    mwStage_t    mwStage;

    fetchUnit u_fetchUnit (
        .clk(clk),
        .rstN(rstN),
        .stall(stall),
        .branchTaken(branchTaken),
        .branchTarget(branchTarget),
        .instrAddr(instrAddr),
        .instr(instr),
        .dInstr(dInstr),
        .dPc(dPc)
    );

    regFile u_regFile (
        .clk(clk),
        .rstN(rstN),
        .rsNum(dInstr.r.rs),
        .rtNum(dInstr.r.rt),
        .wrEn(mwStage.ctrl.regWrite),                       // writeback enable and target
        .wrNum(mwStage.dst),
        .wrData(regCommit.data),
        .rsData(rsData),
        .rtData(rtData)
    );

    decodeStage u_decodeStage (
        .clk(clk),
        .rstN(rstN),
        .dInstr(dInstr),
        .dPc(dPc),
        .stall(stall),
        .hazardFwd(hazardFwd),
        .memFwdData(emStage.aluResult),
        .rsData(rsData),
        .rtData(rtData),
        .dCtrl(dCtrl),
        .branchTaken(branchTaken),
        .branchTarget(branchTarget),
        .deStage(deStage)
    );

    hazardUnit u_hazardUnit (
        .clk(clk),
        .rstN(rstN),
        .dInstr(dInstr),
        .dCtrl(dCtrl),
        .deStage(deStage),
        .emStage(emStage),
        .mwStage(mwStage),
        .stall(stall),
        .hazardFwd(hazardFwd)
    );

    executeStage u_executeStage (
        .clk(clk),
        .rstN(rstN),
        .deStage(deStage),
        .hazardFwd(hazardFwd),
        .memFwdData(emStage.aluResult),                     // ALU result waiting in memory
        .wbData(regCommit.data),
        .emStage(emStage)
    );

    memoryStage u_memoryStage (
        .clk(clk),
        .rstN(rstN),
        .emStage(emStage),
        .hazardFwd(hazardFwd),
        .wbData(regCommit.data),
        .mwStage(mwStage),
        .memCommit(memCommit),
        .regCommit(regCommit)
    );

endmodule

// ==== bench/clockGen.sv ====
`timescale 1ns/1ns

module clockGen (
    output logic clk,
    output logic rstN
);

    initial begin
        clk  = 1'b0;
        rstN = 1'b0;                                        // in reset from time zero
        forever #5 clk = ~clk;                              // 10 ns period
    end

    // release after two rising edges
    initial begin
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
    end

endmodule

// ==== bench/mipsCoreTb.sv ====
`timescale 1ns/1ns
`include "mips_cfg.svh"

module mipsCoreTb import mipsPkg::*; ();

    logic        clk;
    logic        rstN;
    logic [31:0] instrAddr;
    logic [31:0] instr;
    regCommit_t  regCommit;
    memCommit_t  memCommit;

    logic [31:0] rom [1024];                                // program, nop everywhere else
    logic [31:0] dmemModel [1024];
    logic [9:0]  progLen = '0;
    regCommit_t  expReg [64];                               // expected commits in program order
    memCommit_t  expMem [64];
    logic [5:0]  regCount = '0;
    logic [5:0]  memCount = '0;
    logic [5:0]  regIdx = '0;                               // next expected entry
    logic [5:0]  memIdx = '0;
    regCommit_t  regHead;
    memCommit_t  memHead;
    int          cyc = 0;                                   // edges since reset release
    int          valueErrs = 0;
    int          otherErrs = 0;
    int          seed = 4472;

    clockGen u_clockGen (.clk(clk), .rstN(rstN));

    mipsCore u_mipsCore (
        .clk(clk),
        .rstN(rstN),
        .instrAddr(instrAddr),
        .instr(instr),
        .regCommit(regCommit),
        .memCommit(memCommit)
    );

    assign instr   = rom[instrAddr[11:2]];                  // combinational ROM
    assign regHead = expReg[regIdx];
    assign memHead = expMem[memIdx];

    always @(posedge clk) begin
        if (rstN) begin
            cyc <= cyc + 1;
            if (regCommit.valid) regIdx <= regIdx + 6'd1;
            if (memCommit.valid) memIdx <= memIdx + 6'd1;
        end
    end

    task automatic valueError(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        $display("ERROR %s: got 0x%08h expected 0x%08h", name, got, exp);
        valueErrs++;
    endtask

    function automatic logic [31:0] encodeR(input logic [4:0] rs, rt, rd,
                                            input logic [5:0] funct);
        return {`OP_RTYPE, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs, rt,
                                            input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic emit(input logic [31:0] word);
        rom[progLen] = word;
        progLen = progLen + 10'd1;
    endtask

    // ISA-level interpreter, one instruction per step, beq keeps its delay slot
    task automatic runModel();
        logic [31:0] regs [32];
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] nnpc;
        logic [31:0] word;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] addr;
        logic [31:0] res;
        logic [4:0]  dst;
        logic        wr;
        int          steps;
        for (int i = 0; i < 32; i++) regs[i] = '0;
        for (int i = 0; i < 1024; i++) dmemModel[i] = '0;
        pc    = `RESET_PC;
        npc   = `RESET_PC + 32'd4;
        steps = 0;
        while (pc[11:2] < progLen && steps < 200) begin
            word = rom[pc[11:2]];
            a    = regs[word[25:21]];
            b    = regs[word[20:16]];
            imm  = {{16{word[15]}}, word[15:0]};
            nnpc = npc + 32'd4;
            dst  = word[20:16];                             // rt unless R-type
            wr   = 1'b0;
            res  = '0;
            case (word[31:26])
                `OP_RTYPE: begin
                    dst = word[15:11];
                    if (word[5:0] == `FN_ADDU) begin
                        res = a + b;
                        wr  = 1'b1;
                    end else if (word[5:0] == `FN_SUBU) begin
                        res = a - b;
                        wr  = 1'b1;
                    end
                end
                `OP_ORI: begin
                    res = a | {16'h0, word[15:0]};
                    wr  = 1'b1;
                end
                `OP_LUI: begin
                    res = {word[15:0], 16'h0};
                    wr  = 1'b1;
                end
                `OP_LW: begin
                    addr = a + imm;
                    res  = dmemModel[addr[11:2]];
                    wr   = 1'b1;
                end
                `OP_SW: begin
                    addr = a + imm;
                    dmemModel[addr[11:2]] = b;
                    expMem[memCount] = '{valid: 1'b1, pc: pc, addr: addr, data: b};
                    memCount = memCount + 6'd1;
                end
                `OP_BEQ: begin
                    if (a == b) nnpc = pc + 32'd4 + {imm[29:0], 2'b00};  // after the slot
                end
                default: ;
            endcase
            if (wr && dst != 5'd0) begin                    // $0 stays zero and never commits
                regs[dst] = res;
                expReg[regCount] = '{valid: 1'b1, pc: pc, regNum: dst, data: res};
                regCount = regCount + 6'd1;
            end
            pc  = npc;
            npc = nnpc;
            steps++;
        end
    endtask

    task automatic finishRun();
        $display("errors: value %0d, other %0d", valueErrs, otherErrs);
        if (valueErrs + otherErrs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    // reset state and the empty pipe before the first commit
    assert property (@(posedge clk) !rstN |=> instrAddr == `RESET_PC)
        else valueError("instrAddr", $sampled(instrAddr), `RESET_PC);
    assert property (@(posedge clk) disable iff (!rstN) cyc == 0 |-> instrAddr == `RESET_PC)
        else valueError("instrAddr", $sampled(instrAddr), `RESET_PC);
    assert property (@(posedge clk) disable iff (!rstN)
        cyc < 4 |-> !regCommit.valid && !memCommit.valid)
        else begin
            $display("commit seen in cycle %0d, pipe should still be filling", $sampled(cyc));
            otherErrs++;
        end

    // register commits against the head of the expected list
    assert property (@(posedge clk) disable iff (!rstN) regCommit.valid |-> regIdx < regCount)
        else begin
            $display("register commit at pc 0x%08h not expected", $sampled(regCommit.pc));
            otherErrs++;
        end
    assert property (@(posedge clk) disable iff (!rstN)
        regCommit.valid |-> regCommit.pc == regHead.pc)
        else valueError("regCommit.pc", $sampled(regCommit.pc), $sampled(regHead.pc));
    assert property (@(posedge clk) disable iff (!rstN)
        regCommit.valid |-> regCommit.regNum == regHead.regNum)
        else valueError("regCommit.regNum", {27'd0, $sampled(regCommit.regNum)},
                        {27'd0, $sampled(regHead.regNum)});
    assert property (@(posedge clk) disable iff (!rstN)
        regCommit.valid |-> regCommit.data == regHead.data)
        else valueError("regCommit.data", $sampled(regCommit.data), $sampled(regHead.data));

    // store commits
    assert property (@(posedge clk) disable iff (!rstN) memCommit.valid |-> memIdx < memCount)
        else begin
            $display("store commit at pc 0x%08h not expected", $sampled(memCommit.pc));
            otherErrs++;
        end
    assert property (@(posedge clk) disable iff (!rstN)
        memCommit.valid |-> memCommit.pc == memHead.pc)
        else valueError("memCommit.pc", $sampled(memCommit.pc), $sampled(memHead.pc));
    assert property (@(posedge clk) disable iff (!rstN)
        memCommit.valid |-> memCommit.addr == memHead.addr)
        else valueError("memCommit.addr", $sampled(memCommit.addr), $sampled(memHead.addr));
    assert property (@(posedge clk) disable iff (!rstN)
        memCommit.valid |-> memCommit.data == memHead.data)
        else valueError("memCommit.data", $sampled(memCommit.data), $sampled(memHead.data));

    initial begin
        logic [31:0] r;
        logic [15:0] immA;
        logic [15:0] immB;
        logic [15:0] immC;
        logic [15:0] immD;
        logic [15:0] immE;
        int          n;
        for (int i = 0; i < 1024; i++) rom[i] = '0;
        r = $random(seed);
        immA = r[15:0] | 16'h0001;                          // nonzero so $1 != $2
        r = $random(seed);
        immB = r[15:0] | 16'h0001;                          // nonzero so $7 differs from a stale 0
        r = $random(seed);
        immC = r[15:0];
        r = $random(seed);
        immD = r[15:0];
        r = $random(seed);
        immE = r[15:0];

        // dependent ALU chain, mem and wb forwarding into execute
        emit(encodeI(`OP_ORI, 5'd0, 5'd1, immA));
        emit(encodeI(`OP_LUI, 5'd0, 5'd2, immB));
        emit(encodeR(5'd1, 5'd2, 5'd3, `FN_ADDU));
        emit(encodeR(5'd3, 5'd1, 5'd4, `FN_SUBU));
        emit(encodeI(`OP_ORI, 5'd4, 5'd5, immC));
        emit(encodeR(5'd5, 5'd4, 5'd6, `FN_ADDU));
        emit(encodeR(5'd6, 5'd5, 5'd7, `FN_SUBU));
        // store of a fresh result, reload, store of a loaded word
        emit(encodeI(`OP_SW, 5'd0, 5'd7, 16'h0100));
        emit(encodeI(`OP_LW, 5'd0, 5'd8, 16'h0100));
        emit(encodeI(`OP_SW, 5'd0, 5'd8, 16'h0104));        // store data from writeback
        emit(encodeI(`OP_LW, 5'd0, 5'd9, 16'h0104));
        // load-use and load-branch stalls
        emit(encodeI(`OP_LW, 5'd0, 5'd10, 16'h0100));
        emit(encodeR(5'd10, 5'd1, 5'd11, `FN_ADDU));
        emit(encodeI(`OP_LW, 5'd0, 5'd12, 16'h0104));
        emit(encodeI(`OP_BEQ, 5'd12, 5'd7, 16'h0002));      // taken, two stall cycles
        emit(encodeI(`OP_ORI, 5'd0, 5'd13, immD));          // slot
        emit(encodeI(`OP_ORI, 5'd0, 5'd14, immD));          // skipped
        emit(encodeR(5'd13, 5'd11, 5'd15, `FN_ADDU));       // target
        // not taken, slot and fall-through both commit
        emit(encodeI(`OP_BEQ, 5'd1, 5'd2, 16'h0002));
        emit(encodeI(`OP_ORI, 5'd0, 5'd16, immE));
        emit(encodeI(`OP_ORI, 5'd16, 5'd17, immA));
        // taken on an ALU result, compare forwarded from memory
        emit(encodeI(`OP_ORI, 5'd0, 5'd18, immA));
        emit(encodeI(`OP_BEQ, 5'd18, 5'd1, 16'h0002));
        emit(encodeI(`OP_ORI, 5'd0, 5'd21, immC));          // slot
        emit(encodeI(`OP_ORI, 5'd0, 5'd22, immC));          // skipped
        emit(encodeR(5'd21, 5'd18, 5'd23, `FN_ADDU));       // target
        // write to $0 is dropped, reads of $0 stay zero
        emit(encodeI(`OP_ORI, 5'd0, 5'd0, immE));
        emit(encodeR(5'd0, 5'd1, 5'd19, `FN_ADDU));
        emit(encodeR(5'd0, 5'd0, 5'd20, `FN_SUBU));
        runModel();

        n = 0;
        while (!rstN && n < 10) begin
            @(posedge clk);
            n++;
        end
        if (!rstN) begin
            $display("reset never released");
            otherErrs++;
        end

        n = 0;
        while ((regIdx < regCount || memIdx < memCount) && n < 200) begin
            @(posedge clk);
            n++;
        end
        if (regIdx < regCount || memIdx < memCount) begin
            $display("timed out with %0d register and %0d store commits missing",
                     regCount - regIdx, memCount - memIdx);
            otherErrs++;
        end
        repeat (8) @(posedge clk);                          // drain, catches stray commits
        finishRun();
    end

endmodule

// ==== mipsCore.f ====
+incdir+include
hdl/mipsPkg.sv
hdl/fetchUnit.sv
hdl/regFile.sv
hdl/decodeStage.sv
hdl/hazardUnit.sv
hdl/executeStage.sv
hdl/memoryStage.sv
hdl/mipsCore.sv
bench/clockGen.sv
bench/mipsCoreTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mipsCoreTb \
    -f mipsCore.f --Mdir obj_dir -o simv

./obj_dir/simv > sim.log 2>&1
cat sim.log

if grep -q "Done: errors found" sim.log; then
    exit 1
fi
exit 0
